//--- run.sh
#!/bin/sh
# build and run the ISP testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_isp \
    -f verilog.f -o tb_isp > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_isp > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

//--- src/brightness_acc.sv
`include "isp_defines.svh"

module brightness_acc (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            acc_clear,
    input  logic            wr_fire,
    input  isp_pkg::beat_u  wr_beat,
    output isp_pkg::sum_t   bright_sum
);

    import isp_pkg::*;

    logic [7:0]              beat_cnt;
    logic                    green;
    logic [`ISP_PIX_W+3:0]   lane_sum;

    // middle plane is green and weighs double
    assign green = (beat_cnt >= 8'(`ISP_CH_BEATS)) && (beat_cnt < 8'(2 * `ISP_CH_BEATS));

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `ISP_LANES; i++) begin
            if (green) begin
                lane_sum = lane_sum + {4'b0000, wr_beat.lane[i] >> 1};
            end else begin
                lane_sum = lane_sum + {4'b0000, wr_beat.lane[i] >> 2};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bright_sum <= '0;
            beat_cnt   <= '0;
        end else if (acc_clear) begin
            bright_sum <= '0;
            beat_cnt   <= '0;
        end else if (wr_fire) begin
            bright_sum <= bright_sum + sum_t'(lane_sum);
            beat_cnt   <= beat_cnt + 8'd1;
        end
    end

endmodule

//--- src/dram_reader.sv
`include "isp_defines.svh"

module dram_reader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_rd,
    input  logic [`ISP_ADDR_W-1:0]  pic_addr,
    output isp_pkg::axi_ar_t        ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  isp_pkg::axi_r_t         r,
    input  logic                    rvalid,
    output logic                    rready,
    output isp_pkg::beat_u          rd_beat,
    output logic                    rd_valid,
    input  logic                    rd_ready,
    output logic                    rd_done
);

    logic [`ISP_ADDR_W-1:0] addr_q;
    logic                   busy;
    logic                   r_fire;

    // one INCR burst of 16-byte beats over the whole picture
    always_comb begin
        ar.id    = '0;
        ar.addr  = addr_q;
        ar.len   = 8'(`ISP_BEATS - 1);
        ar.size  = 3'b100;
        ar.burst = 2'b01;
    end

    // R channel maps straight onto the beat stream
    assign rready       = busy && rd_ready;
    assign rd_valid     = busy && rvalid;
    assign rd_beat.raw  = r.data;
    assign r_fire       = rvalid && rready;

    always_ff @(posedge clk) begin
        if (start_rd) begin
            addr_q <= pic_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            busy    <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= r_fire && r.last;
            if (start_rd) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            if (start_rd) begin
                busy <= 1'b1;
            end else if (r_fire && r.last) begin
                busy <= 1'b0;
            end
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar));

endmodule

//--- src/dram_writer.sv
`include "isp_defines.svh"

module dram_writer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_wr,
    input  logic [`ISP_ADDR_W-1:0]  pic_addr,
    output isp_pkg::axi_aw_t        aw,
    output logic                    awvalid,
    input  logic                    awready,
    input  isp_pkg::beat_u          sc_beat,
    input  logic                    sc_valid,
    output logic                    sc_ready,
    output isp_pkg::axi_w_t         w,
    output logic                    wvalid,
    input  logic                    wready,
    input  isp_pkg::axi_b_t         b,
    input  logic                    bvalid,
    output logic                    bready,
    output logic                    wr_fire,
    output isp_pkg::beat_u          wr_beat,
    output logic                    wr_done
);

    typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} state_e;

    state_e                 state;
    logic [`ISP_ADDR_W-1:0] addr_q;
    logic [7:0]             beat_cnt;
    logic                   last_beat;

    always_comb begin
        aw.id    = '0;
        aw.addr  = addr_q;
        aw.len   = 8'(`ISP_BEATS - 1);
        aw.size  = 3'b100;
        aw.burst = 2'b01;
    end

    assign awvalid = (state == W_ADDR);
    assign bready  = (state == W_RESP);

    // ---------------------------------------------------------------------------
    // W channel fed straight from the scaled stream
    // ---------------------------------------------------------------------------
    assign last_beat = (beat_cnt == 8'(`ISP_BEATS - 1));
    assign wvalid    = (state == W_DATA) && sc_valid;
    assign sc_ready  = (state == W_DATA) && wready;
    assign w.data    = sc_beat.raw;
    assign w.last    = last_beat;
    assign wr_fire   = wvalid && wready;
    assign wr_beat   = sc_beat;

    always_ff @(posedge clk) begin
        if (start_wr) begin
            addr_q <= pic_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= W_IDLE;
            beat_cnt <= '0;
            wr_done  <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (start_wr) begin
                        beat_cnt <= '0;
                        state    <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (awready) begin
                        state <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (wr_fire) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (last_beat) begin
                            state <= W_RESP;
                        end
                    end
                end
                default: begin
                    if (bvalid) begin
                        wr_done <= 1'b1;
                        state   <= W_IDLE;
                    end
                end
            endcase
        end
    end

    // scaler must hold the beat while the slave stalls
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w));

    // the beat marked last must end the scaled stream
    a_last_ends_stream: assert property (@(posedge clk) disable iff (!rst_n)
        wr_fire && w.last |=> !sc_valid);

    // slave answers OKAY
    a_b_okay: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && bready |-> b.resp == 2'b00);

endmodule

//--- src/exposure_scaler.sv
`include "isp_defines.svh"

module exposure_scaler (
    input  logic             clk,
    input  logic             rst_n,
    input  isp_pkg::ratio_t  ratio,
    input  isp_pkg::beat_u   rd_beat,
    input  logic             rd_valid,
    output logic             rd_ready,
    output isp_pkg::beat_u   sc_beat,
    output logic             sc_valid,
    input  logic             sc_ready
);

    import isp_pkg::*;

    beat_u      scaled;
    logic [1:0] rshift;

    // modes 0..2 divide by 4, 2, 1
    assign rshift   = 2'd2 - ratio;
    assign rd_ready = !sc_valid || sc_ready;

    always_comb begin
        for (int i = 0; i < `ISP_LANES; i++) begin
            if (ratio == 2'd3) begin
                // top bit set means doubling overflows
                if (rd_beat.lane[i][`ISP_PIX_W-1]) begin
                    scaled.lane[i] = '1;
                end else begin
                    scaled.lane[i] = rd_beat.lane[i] << 1;
                end
            end else begin
                scaled.lane[i] = rd_beat.lane[i] >> rshift;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) begin
            sc_beat <= scaled;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sc_valid <= 1'b0;
        end else if (rd_ready) begin
            sc_valid <= rd_valid;
        end
    end

endmodule

//--- src/isp_ctrl.sv
`include "isp_defines.svh"

module isp_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  isp_pkg::isp_req_t       in_req,
    output logic                    start_rd,
    output logic                    start_wr,
    output logic [`ISP_ADDR_W-1:0]  pic_addr,
    output isp_pkg::ratio_t         ratio,
    input  logic                    rd_done,
    input  logic                    wr_done,
    input  isp_pkg::sum_t           bright_sum,
    output logic                    acc_clear,
    output logic                    out_valid,
    output logic [7:0]              out_data
);

    import isp_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_CHECK, S_RUN, S_REPORT} state_e;

    state_e     state;
    isp_req_t   req_q;
    level_t     level_q [`ISP_NUM_PICS];
    level_t     cur_level;
    level_t     next_level;
    logic [4:0] level_sum;
    logic [4:0] level_dec;
    logic       rd_seen;
    logic       wr_seen;
    logic       all_done;
    sum_t       bright_scaled;

    always_ff @(posedge clk) begin
        if (in_valid && state == S_IDLE) begin
            req_q <= in_req;
        end
    end

    // ---------------------------------------------------------------------------
    // level update: old - 2 + ratio, clamped to 0..max
    // ---------------------------------------------------------------------------
    assign cur_level = level_q[req_q.pic_no];
    assign level_sum = {1'b0, cur_level} + {3'b000, req_q.ratio};
    assign level_dec = level_sum - 5'd2;

    always_comb begin
        if (level_sum < 5'd2) begin
            next_level = '0;
        end else if (level_sum > 5'(`ISP_LEVEL_MAX + 2)) begin
            next_level = level_t'(`ISP_LEVEL_MAX);
        end else begin
            next_level = level_dec[3:0];
        end
    end

    // both engines start together from the check state
    assign start_rd  = (state == S_CHECK) && (cur_level != '0);
    assign start_wr  = start_rd;
    assign acc_clear = (state == S_CHECK);
    assign ratio     = req_q.ratio;
    assign pic_addr  = `ISP_PIC_BASE
                     + `ISP_PIC_BYTES * {{(`ISP_ADDR_W - $bits(pic_no_t)){1'b0}}, req_q.pic_no};

    assign all_done      = (rd_seen || rd_done) && (wr_seen || wr_done);
    assign bright_scaled = bright_sum >> 10;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            rd_seen   <= 1'b0;
            wr_seen   <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
            for (int i = 0; i < `ISP_NUM_PICS; i++) begin
                level_q[i] <= level_t'(`ISP_LEVEL_MAX);
            end
        end else begin
            out_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (in_valid) begin
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    rd_seen <= 1'b0;
                    wr_seen <= 1'b0;
                    if (cur_level == '0) begin
                        // fully darkened picture, answer without touching DRAM
                        // and leave its level where it is
                        out_valid <= 1'b1;
                        out_data  <= '0;
                        state     <= S_REPORT;
                    end else begin
                        level_q[req_q.pic_no] <= next_level;
                        state                 <= S_RUN;
                    end
                end
                S_RUN: begin
                    rd_seen <= rd_seen | rd_done;
                    wr_seen <= wr_seen | wr_done;
                    if (all_done) begin
                        out_valid <= 1'b1;
                        out_data  <= bright_scaled[7:0];
                        state     <= S_REPORT;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // host keeps one request open at a time
    a_req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> state == S_IDLE);

endmodule

//--- src/isp_defines.svh
`ifndef ISP_DEFINES_SVH
`define ISP_DEFINES_SVH

// ---------------------------------------------------------------------------
// pixel and bus geometry
// ---------------------------------------------------------------------------
`define ISP_PIX_W      8
`define ISP_LANES      16
`define ISP_DATA_W     128
`define ISP_ADDR_W     32
`define ISP_ID_W       4

// picture layout in DRAM, three colour planes back to back
`define ISP_PIC_BASE   32'h0001_0000
`define ISP_PIC_BYTES  3072
`define ISP_BEATS      192
`define ISP_CH_BEATS   64
`define ISP_NUM_PICS   16

// ---------------------------------------------------------------------------
// exposure bookkeeping
// ---------------------------------------------------------------------------
`define ISP_LEVEL_MAX  8
`define ISP_SUM_W      20

`endif

//--- src/isp_pkg.sv
`include "isp_defines.svh"

package isp_pkg;

    typedef logic [3:0]              pic_no_t;
    typedef logic [1:0]              ratio_t;
    typedef logic [3:0]              level_t;
    typedef logic [`ISP_SUM_W-1:0]   sum_t;

    // bus side uses raw, datapath uses the pixel lanes
    typedef union packed {
        logic [`ISP_DATA_W-1:0]                 raw;
        logic [`ISP_LANES-1:0][`ISP_PIX_W-1:0]  lane;
    } beat_u;

    typedef struct packed {
        pic_no_t pic_no;
        ratio_t  ratio;
    } isp_req_t;

    // ---------------------------------------------------------------------------
    // AXI4 channel payloads
    // ---------------------------------------------------------------------------
    typedef struct packed {
        logic [`ISP_ID_W-1:0]   id;
        logic [`ISP_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`ISP_ID_W-1:0]   id;
        logic [`ISP_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
    } axi_aw_t;

    typedef struct packed {
        logic [`ISP_ID_W-1:0]   id;
        logic [`ISP_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
    } axi_r_t;

    typedef struct packed {
        logic [`ISP_DATA_W-1:0] data;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [`ISP_ID_W-1:0]   id;
        logic [1:0]             resp;
    } axi_b_t;

endpackage

//--- src/isp_top.sv
`include "isp_defines.svh"

module isp_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  isp_pkg::isp_req_t  in_req,
    output logic               out_valid,
    output logic [7:0]         out_data,
    output isp_pkg::axi_ar_t   ar,
    output logic               arvalid,
    input  logic               arready,
    input  isp_pkg::axi_r_t    r,
    input  logic               rvalid,
    output logic               rready,
    output isp_pkg::axi_aw_t   aw,
    output logic               awvalid,
    input  logic               awready,
    output isp_pkg::axi_w_t    w,
    output logic               wvalid,
    input  logic               wready,
    input  isp_pkg::axi_b_t    b,
    input  logic               bvalid,
    output logic               bready
);

    import isp_pkg::*;

    // control between sequencer and the two DRAM engines
    logic                   start_rd;
    logic                   start_wr;
    logic                   rd_done;
    logic                   wr_done;
    logic                   acc_clear;
    logic [`ISP_ADDR_W-1:0] pic_addr;
    ratio_t                 ratio;
    sum_t                   bright_sum;

    // beat streams
    beat_u                  rd_beat;
    logic                   rd_valid;
    logic                   rd_ready;
    beat_u                  sc_beat;
    logic                   sc_valid;
    logic                   sc_ready;
    beat_u                  wr_beat;
    logic                   wr_fire;

    // every port name matches its net here
    isp_ctrl i_ctrl (.*);

    dram_reader i_reader (.*);

    exposure_scaler i_scaler (.*);

    dram_writer i_writer (.*);

    brightness_acc i_acc (.*);

endmodule

//--- tests/axi_mem_model.sv
`include "isp_defines.svh"

module axi_mem_model #(
    parameter int BRIGHT_PIC = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  isp_pkg::axi_ar_t  ar,
    input  logic              arvalid,
    output logic              arready,
    output isp_pkg::axi_r_t   r,
    output logic              rvalid,
    input  logic              rready,
    input  isp_pkg::axi_aw_t  aw,
    input  logic              awvalid,
    output logic              awready,
    input  isp_pkg::axi_w_t   w,
    input  logic              wvalid,
    output logic              wready,
    output isp_pkg::axi_b_t   b,
    output logic              bvalid,
    input  logic              bready
);
    timeunit 1ns;
    timeprecision 1ps;

    import isp_pkg::*;

    localparam int MEM_BEATS = `ISP_NUM_PICS * `ISP_BEATS;

    logic [`ISP_DATA_W-1:0] mem [MEM_BEATS];
    int                     ar_count = 0;
    int                     aw_count = 0;
    int                     errors = 0;
    logic [31:0]            rnd;
    int                     rd_idx;
    int                     rd_left;
    int                     wr_idx;
    int                     wr_left;
    logic                   rd_active;
    logic                   wr_active;
    logic                   ar_fire;
    logic                   r_fire;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   b_fire;
    axi_ar_t                ar_s;
    axi_aw_t                aw_s;
    axi_w_t                 w_s;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        logic [`ISP_DATA_W-1:0] word;
        // -----------------------------------------------------------------------
        // random picture contents with one bright picture for saturation
        // -----------------------------------------------------------------------
        rnd = 32'd27;
        for (int k = 0; k < MEM_BEATS; k++) begin
            for (int j = 0; j < 4; j++) begin
                rnd = xorshift32(rnd);
                word[j*32 +: 32] = rnd;
            end
            if (k / `ISP_BEATS == BRIGHT_PIC) begin
                word = word | {`ISP_LANES{8'h80}};
            end
            mem[k] = word;
        end
        arready   = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        rvalid    = 1'b0;
        bvalid    = 1'b0;
        r         = '0;
        b         = '0;
        rd_active = 1'b0;
        wr_active = 1'b0;
        rd_idx    = 0;
        rd_left   = 0;
        wr_idx    = 0;
        wr_left   = 0;
        forever begin
            // handshakes are settled by the falling edge
            @(negedge clk);
            ar_fire = arvalid && arready;
            r_fire  = rvalid && rready;
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            b_fire  = bvalid && bready;
            ar_s    = ar;
            aw_s    = aw;
            w_s     = w;
            @(posedge clk);
            #5;
            if (!rst_n) begin
                arready   = 1'b0;
                awready   = 1'b0;
                wready    = 1'b0;
                rvalid    = 1'b0;
                bvalid    = 1'b0;
                rd_active = 1'b0;
                wr_active = 1'b0;
            end else begin
                rnd = xorshift32(rnd);
                if (ar_fire) begin
                    rd_active = 1'b1;
                    rd_idx    = int'((ar_s.addr - `ISP_PIC_BASE) >> 4);
                    rd_left   = int'(ar_s.len) + 1;
                    ar_count++;
                    if (ar_s.burst != 2'b01 || ar_s.size != 3'b100 || ar_s.id != '0) begin
                        $display("read burst is not a one-ID INCR burst of 16-byte beats");
                        errors++;
                    end
                end
                if (r_fire) begin
                    rd_idx++;
                    rd_left--;
                    if (rd_left == 0) begin
                        rd_active = 1'b0;
                    end
                end
                // a raised rvalid stays until the beat is taken
                if (!rvalid || r_fire) begin
                    rvalid = rd_active && (rnd[7:6] != 2'b00);
                    r.id   = '0;
                    r.data = mem[rd_idx];
                    r.resp = 2'b00;
                    r.last = (rd_left == 1);
                end
                if (b_fire) begin
                    bvalid = 1'b0;
                end
                if (aw_fire) begin
                    wr_active = 1'b1;
                    wr_idx    = int'((aw_s.addr - `ISP_PIC_BASE) >> 4);
                    wr_left   = int'(aw_s.len) + 1;
                    aw_count++;
                    if (aw_s.burst != 2'b01 || aw_s.size != 3'b100 || aw_s.id != '0) begin
                        $display("write burst is not a one-ID INCR burst of 16-byte beats");
                        errors++;
                    end
                end
                if (w_fire) begin
                    mem[wr_idx] = w_s.data;
                    if (w_s.last != (wr_left == 1)) begin
                        $display("write last flag on the wrong beat, %0d beats left", wr_left);
                        errors++;
                    end
                    wr_idx++;
                    wr_left--;
                    if (wr_left == 0) begin
                        wr_active = 1'b0;
                        bvalid    = 1'b1;
                        b         = '0;
                    end
                end
                arready = !rd_active && (rnd[1:0] != 2'b00);
                awready = !wr_active && !bvalid && (rnd[3:2] != 2'b00);
                wready  = wr_active && (rnd[5:4] != 2'b00);
            end
        end
    end

endmodule

//--- tests/tb_isp.sv
`include "isp_defines.svh"

module tb_isp;
    timeunit 1ns;
    timeprecision 1ps;

    import isp_pkg::*;

    localparam int MEM_BEATS      = `ISP_NUM_PICS * `ISP_BEATS;
    localparam int REQUESTS       = 12;
    localparam int TIMEOUT_CYCLES = REQUESTS * 800 + 8;

    typedef struct packed {
        logic [7:0]  data;
        logic        shortcut;
        logic [31:0] sent_cycle;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    isp_req_t    in_req;
    logic        out_valid;
    logic [7:0]  out_data;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    axi_aw_t     aw;
    logic        awvalid;
    logic        awready;
    axi_w_t      w;
    logic        wvalid;
    logic        wready;
    axi_b_t      b;
    logic        bvalid;
    logic        bready;

    logic [`ISP_DATA_W-1:0] shadow [MEM_BEATS];
    level_t                 levels [`ISP_NUM_PICS];
    expect_t                cur_exp;
    logic [31:0]            cycles = '0;
    logic [31:0]            rnd;
    int                     n_sent = 0;
    int                     n_checked = 0;
    int                     errors = 0;
    int                     bursts_expected = 0;
    int                     tests_run = 0;
    int                     tests_passed = 0;

    isp_top i_dut (.*);

    axi_mem_model i_mem (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 32'd1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ---------------------------------------------------------------------------
    // reference model that scales the shadow picture in place
    // ---------------------------------------------------------------------------
    function automatic logic [7:0] ref_expose(input pic_no_t pic, input ratio_t ratio);
        int base;
        int total;
        int pix;
        int scaled;
        base  = int'(pic) * `ISP_BEATS;
        total = 0;
        for (int k = 0; k < `ISP_BEATS; k++) begin
            for (int l = 0; l < `ISP_LANES; l++) begin
                pix    = int'(shadow[base + k][l*8 +: 8]);
                scaled = pix * (1 << ratio) / 4;
                if (scaled > 255) begin
                    scaled = 255;
                end
                shadow[base + k][l*8 +: 8] = scaled[7:0];
                // green plane counts double
                if (k >= `ISP_CH_BEATS && k < 2 * `ISP_CH_BEATS) begin
                    total += scaled >> 1;
                end else begin
                    total += scaled >> 2;
                end
            end
        end
        return 8'(total >> 10);
    endfunction

    function automatic level_t level_after(input level_t lv, input ratio_t ratio);
        int v;
        v = int'(lv) - 2 + int'(ratio);
        if (v < 0) begin
            v = 0;
        end
        if (v > `ISP_LEVEL_MAX) begin
            v = `ISP_LEVEL_MAX;
        end
        return level_t'(v);
    endfunction

    function automatic int total_errors();
        return errors + i_mem.errors;
    endfunction

    // first differing beat anywhere in DRAM
    function automatic void check_memory();
        for (int k = 0; k < MEM_BEATS; k++) begin
            if (i_mem.mem[k] !== shadow[k]) begin
                $display("[FAIL] mem[%h]: got %h, expected %h", k, i_mem.mem[k], shadow[k]);
                errors++;
                break;
            end
        end
    endfunction

    // compare on every result at mid cycle
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (n_checked >= n_sent) begin
                $display("out_valid came while no request was open");
                errors++;
            end else begin
                if (out_data !== cur_exp.data) begin
                    $display("[FAIL] out_data: got %h, expected %h", out_data, cur_exp.data);
                    errors++;
                end
                if (cur_exp.shortcut && (cycles - cur_exp.sent_cycle) != 32'd2) begin
                    $display("shortcut answer took %0d cycles instead of 2",
                             cycles - cur_exp.sent_cycle);
                    errors++;
                end
                if (i_mem.ar_count != bursts_expected) begin
                    $display("[FAIL] ar_count: got %h, expected %h",
                             i_mem.ar_count, bursts_expected);
                    errors++;
                end
                if (i_mem.aw_count != bursts_expected) begin
                    $display("[FAIL] aw_count: got %h, expected %h",
                             i_mem.aw_count, bursts_expected);
                    errors++;
                end
                check_memory();
                n_checked++;
            end
        end
    end

    task automatic run_request(input pic_no_t pic, input ratio_t ratio);
        expect_t e;
        e.shortcut = (levels[pic] == '0);
        if (e.shortcut) begin
            e.data = '0;
        end else begin
            e.data      = ref_expose(pic, ratio);
            levels[pic] = level_after(levels[pic], ratio);
            bursts_expected++;
        end
        @(posedge clk);
        #5;
        e.sent_cycle  = cycles;
        cur_exp       = e;
        in_req.pic_no = pic;
        in_req.ratio  = ratio;
        in_valid      = 1'b1;
        n_sent++;
        @(posedge clk);
        #5;
        in_valid = 1'b0;
        while (n_checked < n_sent) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d failed checks", name, total_errors() - errs_before);
        end
    endtask

    initial begin
        int errs;
        in_valid = 1'b0;
        in_req   = '0;
        rst_n    = 1'b0;
        rnd      = 32'd27;
        for (int k = 0; k < `ISP_NUM_PICS; k++) begin
            levels[k] = level_t'(`ISP_LEVEL_MAX);
        end
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int k = 0; k < MEM_BEATS; k++) begin
            shadow[k] = i_mem.mem[k];
        end

        errs = total_errors();
        run_request(4'd0, 2'd2);
        report_test("unity ratio", errs);

        errs = total_errors();
        run_request(4'd1, 2'd0);
        run_request(4'd2, 2'd1);
        report_test("quarter and half", errs);

        errs = total_errors();
        run_request(4'd3, 2'd3);
        report_test("double with saturation", errs);

        // 8, 6, 4, 2, 0 then the shortcut
        errs = total_errors();
        repeat (5) run_request(4'd4, 2'd0);
        report_test("level down to zero", errs);

        errs = total_errors();
        repeat (3) begin
            rnd = xorshift32(rnd);
            run_request(pic_no_t'(rnd[3:0]), ratio_t'(rnd[9:8]));
        end
        report_test("random requests", errs);

        $display("%0d of %0d tests passed, %0d failed checks",
                 tests_passed, tests_run, total_errors());
        if (total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/isp_pkg.sv
src/isp_ctrl.sv
src/dram_reader.sv
src/exposure_scaler.sv
src/dram_writer.sv
src/brightness_acc.sv
src/isp_top.sv
tests/axi_mem_model.sv
tests/tb_isp.sv
